//--- files.f
itf_pkg.sv
link_fsm.sv
inbound_router.sv
outbound_mux.sv
state_monitor.sv
chip_itf.sv
chip_itf_props.sv
tb_chip_itf.sv

//--- tb_chip_itf.sv
// ----------------------------------------
// Testbench for the chip-edge interface
// Random bursts checked against a cycle model
// ----------------------------------------
`timescale 1ns/100ps

module tb_chip_itf;

    import itf_pkg::*;

    localparam int PORT_WIDTH = 32;
    localparam int PHASE_LEN  = 600;
    localparam int RST_CYC    = 4;
    // Four phases plus reset and margin
    localparam int CYC_LIMIT  = 3000;

    logic                   OffClk;
    logic                   rst_n;
    logic [PORT_WIDTH-1:0]  dat_i;
    logic [PORT_WIDTH-1:0]  dat_o;
    logic [PORT_WIDTH-1:0]  gic_dat_o;
    logic [PORT_WIDTH-1:0]  gic_dat_i;
    logic [PORT_WIDTH-1:0]  ccu_dat_o;
    logic [PORT_WIDTH-1:0]  mon_dat_i;
    logic                   dat_vld_i, dat_last_i, isa_vld_i, dat_rdy_o;
    logic                   dat_vld_o, dat_last_o, cmd_vld_o, dat_rdy_i;
    logic                   off_oe_i, byp_oe_i, dat_oe_o;
    logic                   gic_vld_o, gic_last_o, gic_rdy_i;
    logic                   gic_vld_i, gic_last_i, gic_cmd_i, gic_rdy_o;
    logic                   ccu_vld_o, ccu_last_o, ccu_rdy_i;
    logic [CFG_RDY_W-1:0]   ccu_cfg_rdy_i;
    logic [CCU_STATE_W-1:0] ccu_state_i;
    logic                   mon_vld_i, mon_last_i, mon_rdy_o;
    logic [MON_SEL_W-1:0]   mon_sel_i;
    logic                   mon_bit_o;

    // Reference model state
    xfer_state_t            m_state;
    xfer_state_t            n_state;
    logic [MON_SNAP_W-1:0]  m_snap;
    logic [MON_SNAP_W-1:0]  n_snap;
    int                     seed;
    int                     errors;
    int                     checks;
    int                     cycles;
    int                     phase;

    chip_itf #(
        .PORT_WIDTH (PORT_WIDTH)
    ) chip_itf_inst (.*);

    initial begin
        OffClk = 1'b0;
        forever #5 OffClk = ~OffClk;
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_word(input logic [PORT_WIDTH-1:0] got,
                              input logic [PORT_WIDTH-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_state(input xfer_state_t got, input xfer_state_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Phase 0 GIC inbound, 1 CCU inbound, 2 outbound, 3 everything mixed
    task automatic drive_inputs(input int ph);
        logic in_en;
        logic out_en;
        in_en  = (ph != 2) || (m_state == XFER_IN2CHIP);
        out_en = (ph >= 2) || (m_state == XFER_OUT2OFF);
        dat_i         = $random(seed);
        dat_vld_i     = in_en & (($random(seed) & 3) != 0);
        dat_last_i    = (($random(seed) & 3) == 0);
        isa_vld_i     = (ph == 1) ? 1'b1 : (ph == 0) ? 1'b0 : $random(seed);
        gic_rdy_i     = $random(seed);
        ccu_rdy_i     = $random(seed);
        gic_dat_i     = $random(seed);
        gic_vld_i     = out_en & (($random(seed) & 3) != 0);
        gic_last_i    = (($random(seed) & 3) == 0);
        gic_cmd_i     = $random(seed);
        mon_dat_i     = $random(seed);
        mon_vld_i     = out_en & (($random(seed) & 3) == 0);
        mon_last_i    = $random(seed);
        dat_rdy_i     = $random(seed);
        off_oe_i      = $random(seed);
        byp_oe_i      = (($random(seed) & 3) == 0);
        ccu_cfg_rdy_i = $random(seed);
        ccu_state_i   = $random(seed);
        mon_sel_i     = $random(seed);
    endtask

    // Expected outputs this cycle and the model's next state
    task automatic check_cycle();
        logic in_act, out_act, to_gic, to_ccu, sel_mon, gic_word;
        logic e_vld, e_last, e_in_rdy, e_mon_bit;
        in_act   = (m_state == XFER_IN2CHIP);
        out_act  = (m_state == XFER_OUT2OFF);
        to_gic   = in_act & ~isa_vld_i;
        to_ccu   = in_act & isa_vld_i;
        sel_mon  = out_act & mon_vld_i;
        gic_word = out_act & ~mon_vld_i & gic_vld_i;
        e_vld    = sel_mon | gic_word;
        e_last   = sel_mon ? mon_last_i : (gic_word & gic_last_i);
        e_in_rdy = (to_gic & gic_rdy_i) | (to_ccu & ccu_rdy_i);
        e_mon_bit = (mon_sel_i < MON_SEL_ZERO_FROM) ? m_snap[mon_sel_i] : 1'b0;

        check_state(chip_itf_inst.xfer_state, m_state, "transfer state");
        check_word(gic_dat_o, to_gic ? dat_i : '0, "gic_dat_o");
        check_bit(gic_vld_o, to_gic & dat_vld_i, "gic_vld_o");
        check_bit(gic_last_o, to_gic & dat_last_i, "gic_last_o");
        check_word(ccu_dat_o, to_ccu ? dat_i : '0, "ccu_dat_o");
        check_bit(ccu_vld_o, to_ccu & dat_vld_i, "ccu_vld_o");
        check_bit(ccu_last_o, to_ccu & dat_last_i, "ccu_last_o");
        check_bit(dat_rdy_o, e_in_rdy, "dat_rdy_o");
        check_word(dat_o, sel_mon ? mon_dat_i : gic_word ? gic_dat_i : '0, "dat_o");
        check_bit(dat_vld_o, e_vld, "dat_vld_o");
        check_bit(dat_last_o, e_last, "dat_last_o");
        check_bit(cmd_vld_o, gic_word & gic_cmd_i, "cmd_vld_o");
        check_bit(mon_rdy_o, sel_mon & dat_rdy_i, "mon_rdy_o");
        check_bit(gic_rdy_o, out_act & ~mon_vld_i & dat_rdy_i, "gic_rdy_o");
        check_bit(dat_oe_o, byp_oe_i ? off_oe_i : e_vld, "dat_oe_o");
        check_bit(mon_bit_o, e_mon_bit, "mon_bit_o");

        n_state = m_state;
        if (!rst_n) begin
            n_state = XFER_IDLE;
        end else if (m_state == XFER_IDLE) begin
            if (dat_vld_i) begin
                n_state = XFER_IN2CHIP;
            end else if (gic_vld_i | mon_vld_i) begin
                n_state = XFER_OUT2OFF;
            end
        end else if (in_act & dat_last_i & dat_vld_i & e_in_rdy) begin
            n_state = XFER_IDLE;
        end else if (out_act & e_last & e_vld & dat_rdy_i) begin
            n_state = XFER_IDLE;
        end
        n_snap = rst_n ? {ccu_state_i, m_state, ccu_cfg_rdy_i} : '0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed    = 57398;
        errors  = 0;
        checks  = 0;
        m_state = XFER_IDLE;
        n_state = XFER_IDLE;
        m_snap  = '0;
        n_snap  = '0;
        rst_n   = 1'b0;
        drive_inputs(3);
        for (int cyc = 0; cyc < RST_CYC + 4 * PHASE_LEN; cyc++) begin
            @(posedge OffClk);
            m_state = n_state;
            m_snap  = n_snap;
            #1;
            rst_n = (cyc >= RST_CYC);
            phase = (cyc < RST_CYC) ? 3 : (cyc - RST_CYC) / PHASE_LEN;
            drive_inputs(phase);
            #3;
            check_cycle();
        end
        errors += chip_itf_inst.props_inst.fail_cnt;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)",
                 checks, errors, chip_itf_inst.props_inst.fail_cnt);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < CYC_LIMIT) begin
            @(posedge OffClk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYC_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_chip_itf

//--- chip_itf_props.sv
// ----------------------------------------
// Handshake properties of the chip interface
// ----------------------------------------
`timescale 1ns/100ps

module chip_itf_props (
    input logic                 OffClk,
    input logic                 rst_n,
    input itf_pkg::xfer_state_t state_i,
    input logic                 gic_rdy_i,
    input logic                 mon_rdy_i,
    input logic                 dat_rdy_i,
    input logic                 dat_vld_i,
    input logic                 gic_vld_i,
    input logic                 ccu_vld_i
);

    import itf_pkg::*;

    int fail_cnt = 0;

    // Only one outbound source is granted
    a_one_src_rdy: assert property (@(posedge OffClk) disable iff (!rst_n)
        !(gic_rdy_i && mon_rdy_i))
    else begin
        $error("GIC ready and monitor ready are high together");
        fail_cnt++;
    end

    // Port never runs both directions at once
    a_one_dir: assert property (@(posedge OffClk) disable iff (!rst_n)
        !(dat_rdy_i && dat_vld_i))
    else begin
        $error("Inbound ready and outbound valid are high together");
        fail_cnt++;
    end

    a_idle_quiet: assert property (@(posedge OffClk) disable iff (!rst_n)
        (state_i == XFER_IDLE) |-> !(dat_vld_i || gic_vld_i || ccu_vld_i))
    else begin
        $error("An output valid is high while the transfer state is idle");
        fail_cnt++;
    end

endmodule : chip_itf_props

bind chip_itf chip_itf_props props_inst (
    .OffClk    (OffClk),
    .rst_n     (rst_n),
    .state_i   (xfer_state),
    .gic_rdy_i (gic_rdy_o),
    .mon_rdy_i (mon_rdy_o),
    .dat_rdy_i (dat_rdy_o),
    .dat_vld_i (dat_vld_o),
    .gic_vld_i (gic_vld_o),
    .ccu_vld_i (ccu_vld_o)
);

//--- chip_itf.sv
// --------------------------------------
// Chip-edge transfer interface, top level
// Joins off-chip burst port to GIC, CCU and monitor
// --------------------------------------
`timescale 1ns/100ps

module chip_itf #(
    parameter int PORT_WIDTH = 128
) (
    input  logic                                OffClk,
    input  logic                                rst_n,
    // Off-chip inbound
    input  logic [PORT_WIDTH-1:0]               dat_i,
    input  logic                                dat_vld_i,
    input  logic                                dat_last_i,
    input  logic                                isa_vld_i,
    output logic                                dat_rdy_o,
    // Off-chip outbound
    output logic [PORT_WIDTH-1:0]               dat_o,
    output logic                                dat_vld_o,
    output logic                                dat_last_o,
    output logic                                cmd_vld_o,
    input  logic                                dat_rdy_i,
    // Output enable
    input  logic                                off_oe_i,
    input  logic                                byp_oe_i,
    output logic                                dat_oe_o,
    // GIC inbound
    output logic [PORT_WIDTH-1:0]               gic_dat_o,
    output logic                                gic_vld_o,
    output logic                                gic_last_o,
    input  logic                                gic_rdy_i,
    // GIC outbound
    input  logic [PORT_WIDTH-1:0]               gic_dat_i,
    input  logic                                gic_vld_i,
    input  logic                                gic_last_i,
    input  logic                                gic_cmd_i,
    output logic                                gic_rdy_o,
    // CCU
    output logic [PORT_WIDTH-1:0]               ccu_dat_o,
    output logic                                ccu_vld_o,
    output logic                                ccu_last_o,
    input  logic                                ccu_rdy_i,
    input  logic [itf_pkg::CFG_RDY_W-1:0]       ccu_cfg_rdy_i,
    input  logic [itf_pkg::CCU_STATE_W-1:0]     ccu_state_i,
    // Monitor source
    input  logic [PORT_WIDTH-1:0]               mon_dat_i,
    input  logic                                mon_vld_i,
    input  logic                                mon_last_i,
    output logic                                mon_rdy_o,
    // Monitor pin
    input  logic [itf_pkg::MON_SEL_W-1:0]       mon_sel_i,
    output logic                                mon_bit_o
);

    import itf_pkg::*;

    xfer_state_t xfer_state;

    // --------------------------------------
    // Direction control
    // --------------------------------------
    // Sees burst ends through the port-side handshakes
    link_fsm u_link_fsm (
        .OffClk     (OffClk),
        .rst_n      (rst_n),
        .dat_vld_i  (dat_vld_i),
        .dat_last_i (dat_last_i),
        .in_rdy_i   (dat_rdy_o),
        .gic_vld_i  (gic_vld_i),
        .mon_vld_i  (mon_vld_i),
        .out_vld_i  (dat_vld_o),
        .out_last_i (dat_last_o),
        .dat_rdy_i  (dat_rdy_i),
        .state_o    (xfer_state)
    );

    inbound_router #(
        .PORT_WIDTH (PORT_WIDTH)
    ) u_inbound_router (
        .state_i    (xfer_state),
        .dat_i      (dat_i),
        .dat_vld_i  (dat_vld_i),
        .dat_last_i (dat_last_i),
        .isa_vld_i  (isa_vld_i),
        .dat_rdy_o  (dat_rdy_o),
        .gic_rdy_i  (gic_rdy_i),
        .ccu_rdy_i  (ccu_rdy_i),
        .gic_dat_o  (gic_dat_o),
        .gic_vld_o  (gic_vld_o),
        .gic_last_o (gic_last_o),
        .ccu_dat_o  (ccu_dat_o),
        .ccu_vld_o  (ccu_vld_o),
        .ccu_last_o (ccu_last_o)
    );

    outbound_mux #(
        .PORT_WIDTH (PORT_WIDTH)
    ) u_outbound_mux (
        .state_i    (xfer_state),
        .gic_dat_i  (gic_dat_i),
        .gic_vld_i  (gic_vld_i),
        .gic_last_i (gic_last_i),
        .gic_cmd_i  (gic_cmd_i),
        .gic_rdy_o  (gic_rdy_o),
        .mon_dat_i  (mon_dat_i),
        .mon_vld_i  (mon_vld_i),
        .mon_last_i (mon_last_i),
        .mon_rdy_o  (mon_rdy_o),
        .dat_rdy_i  (dat_rdy_i),
        .off_oe_i   (off_oe_i),
        .byp_oe_i   (byp_oe_i),
        .dat_o      (dat_o),
        .dat_vld_o  (dat_vld_o),
        .dat_last_o (dat_last_o),
        .cmd_vld_o  (cmd_vld_o),
        .dat_oe_o   (dat_oe_o)
    );

    // Status pin
    state_monitor u_state_monitor (
        .OffClk      (OffClk),
        .rst_n       (rst_n),
        .state_i     (xfer_state),
        .cfg_rdy_i   (ccu_cfg_rdy_i),
        .ccu_state_i (ccu_state_i),
        .mon_sel_i   (mon_sel_i),
        .mon_bit_o   (mon_bit_o)
    );

endmodule : chip_itf

//--- state_monitor.sv
// --------------------------------------
// Status snapshot and monitor pin select
// --------------------------------------
`timescale 1ns/100ps

module state_monitor (
    input  logic                                OffClk,
    input  logic                                rst_n,
    input  itf_pkg::xfer_state_t                state_i,
    input  logic [itf_pkg::CFG_RDY_W-1:0]       cfg_rdy_i,
    input  logic [itf_pkg::CCU_STATE_W-1:0]     ccu_state_i,
    input  logic [itf_pkg::MON_SEL_W-1:0]       mon_sel_i,
    output logic                                mon_bit_o
);

    import itf_pkg::*;

    logic [MON_SNAP_W-1:0] snap_d;
    logic [MON_SNAP_W-1:0] snap_q;
    logic                  sel_valid;

    // --------------------------------------
    // Snapshot, one cycle behind the inputs
    // --------------------------------------
    // cfg ready in the low bits, CCU state on top
    assign snap_d = {ccu_state_i, state_i, cfg_rdy_i};

    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            snap_q <= '0;
        end else begin
            snap_q <= snap_d;
        end
    end

    // --------------------------------------
    // Bit select
    // --------------------------------------
    // Upper codes used to carry raw clocks, now they read zero
    assign sel_valid = (int'(mon_sel_i) < MON_SEL_ZERO_FROM);

    always_comb begin
        mon_bit_o = 1'b0;
        if (sel_valid) begin
            mon_bit_o = snap_q[mon_sel_i];
        end
    end

endmodule : state_monitor

//--- outbound_mux.sv
// --------------------------------------
// Outbound source select and output enable
// Monitor source takes priority over GIC
// --------------------------------------
`timescale 1ns/100ps

module outbound_mux #(
    parameter int PORT_WIDTH = 128
) (
    input  itf_pkg::xfer_state_t    state_i,
    // GIC source
    input  logic [PORT_WIDTH-1:0]   gic_dat_i,
    input  logic                    gic_vld_i,
    input  logic                    gic_last_i,
    input  logic                    gic_cmd_i,
    output logic                    gic_rdy_o,
    // Monitor source
    input  logic [PORT_WIDTH-1:0]   mon_dat_i,
    input  logic                    mon_vld_i,
    input  logic                    mon_last_i,
    output logic                    mon_rdy_o,
    // Off-chip outbound port
    input  logic                    dat_rdy_i,
    input  logic                    off_oe_i,
    input  logic                    byp_oe_i,
    output logic [PORT_WIDTH-1:0]   dat_o,
    output logic                    dat_vld_o,
    output logic                    dat_last_o,
    output logic                    cmd_vld_o,
    output logic                    dat_oe_o
);

    import itf_pkg::*;

    logic out_act;
    logic sel_mon;
    logic sel_gic;

    assign out_act = (state_i == XFER_OUT2OFF);

    // Monitor first, GIC only while monitor is idle
    assign sel_mon = out_act & mon_vld_i;
    assign sel_gic = out_act & ~mon_vld_i;

    assign dat_o      = sel_mon ? mon_dat_i :
                        (sel_gic & gic_vld_i) ? gic_dat_i : '0;
    assign dat_vld_o  = sel_mon | (sel_gic & gic_vld_i);
    assign dat_last_o = (sel_mon & mon_last_i) | (sel_gic & gic_vld_i & gic_last_i);

    // Command flag belongs to GIC words only
    assign cmd_vld_o  = sel_gic & gic_vld_i & gic_cmd_i;

    assign mon_rdy_o  = sel_mon & dat_rdy_i;
    assign gic_rdy_o  = sel_gic & dat_rdy_i;

    // Off-chip override of the pad direction
    assign dat_oe_o   = byp_oe_i ? off_oe_i : dat_vld_o;

endmodule : outbound_mux

//--- inbound_router.sv
// --------------------------------------
// Inbound router, off-chip words to GIC or CCU
// --------------------------------------
`timescale 1ns/100ps

module inbound_router #(
    parameter int PORT_WIDTH = 128
) (
    input  itf_pkg::xfer_state_t    state_i,
    // Off-chip inbound port
    input  logic [PORT_WIDTH-1:0]   dat_i,
    input  logic                    dat_vld_i,
    input  logic                    dat_last_i,
    input  logic                    isa_vld_i,
    output logic                    dat_rdy_o,
    // Receiver readies
    input  logic                    gic_rdy_i,
    input  logic                    ccu_rdy_i,
    // GIC receiver
    output logic [PORT_WIDTH-1:0]   gic_dat_o,
    output logic                    gic_vld_o,
    output logic                    gic_last_o,
    // CCU instruction reader
    output logic [PORT_WIDTH-1:0]   ccu_dat_o,
    output logic                    ccu_vld_o,
    output logic                    ccu_last_o
);

    import itf_pkg::*;

    logic in_act;
    logic to_ccu;
    logic to_gic;

    assign in_act = (state_i == XFER_IN2CHIP);

    // ISA words go to the instruction reader
    assign to_ccu = in_act & isa_vld_i;
    assign to_gic = in_act & ~isa_vld_i;

    assign dat_rdy_o  = (to_ccu & ccu_rdy_i) | (to_gic & gic_rdy_i);

    assign gic_dat_o  = to_gic ? dat_i : '0;
    assign gic_vld_o  = to_gic & dat_vld_i;
    assign gic_last_o = to_gic & dat_last_i;

    assign ccu_dat_o  = to_ccu ? dat_i : '0;
    assign ccu_vld_o  = to_ccu & dat_vld_i;
    assign ccu_last_o = to_ccu & dat_last_i;

endmodule : inbound_router

//--- link_fsm.sv
// --------------------------------------
// Direction FSM for the off-chip port
// Picks idle, inbound or outbound transfer
// --------------------------------------
`timescale 1ns/100ps

module link_fsm (
    input  logic                OffClk,
    input  logic                rst_n,
    // Inbound side
    input  logic                dat_vld_i,
    input  logic                dat_last_i,
    input  logic                in_rdy_i,
    // Outbound side
    input  logic                gic_vld_i,
    input  logic                mon_vld_i,
    input  logic                out_vld_i,
    input  logic                out_last_i,
    input  logic                dat_rdy_i,
    // Current direction
    output itf_pkg::xfer_state_t state_o
);

    import itf_pkg::*;

    xfer_state_t state_q;
    xfer_state_t state_d;
    logic        in_done;
    logic        out_done;

    // Last word of a burst accepted in each direction
    assign in_done  = dat_last_i & dat_vld_i & in_rdy_i;
    assign out_done = out_last_i & out_vld_i & dat_rdy_i;

    // --------------------------------------
    // Next state
    // --------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            XFER_IDLE: begin
                // Inbound wins when both sides are pending
                if (dat_vld_i) begin
                    state_d = XFER_IN2CHIP;
                end else if (gic_vld_i | mon_vld_i) begin
                    state_d = XFER_OUT2OFF;
                end
            end
            XFER_IN2CHIP: begin
                if (in_done) begin
                    state_d = XFER_IDLE;
                end
            end
            XFER_OUT2OFF: begin
                if (out_done) begin
                    state_d = XFER_IDLE;
                end
            end
            default: begin
                state_d = XFER_IDLE;
            end
        endcase
    end

    // --------------------------------------
    // State register
    // --------------------------------------
    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= XFER_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

endmodule : link_fsm

//--- itf_pkg.sv
// --------------------------------------
// Chip interface shared definitions
// Transfer state, field widths, monitor codes
// --------------------------------------
package itf_pkg;

    // --------------------------------------
    // Transfer direction
    // --------------------------------------
    typedef enum logic [1:0] {
        XFER_IDLE    = 2'd0,
        XFER_IN2CHIP = 2'd1,
        XFER_OUT2OFF = 2'd2
    } xfer_state_t;

    // --------------------------------------
    // Field widths
    // --------------------------------------
    // Configuration-ready bits from the CCU
    localparam int CFG_RDY_W   = 6;

    // CCU state code
    localparam int CCU_STATE_W = 4;

    // Monitor select lines
    localparam int MON_SEL_W   = 4;

    // Snapshot order, low to high: cfg ready, transfer state, CCU state
    localparam int MON_SNAP_W  = CFG_RDY_W + $bits(xfer_state_t) + CCU_STATE_W;

    // --------------------------------------
    // Monitor select codes
    // --------------------------------------
    // Codes below this index the snapshot directly, the rest read zero
    localparam int MON_SEL_ZERO_FROM = 12;

endpackage : itf_pkg
